/* src/busPkg.sv */
`default_nettype none

package busPkg;

    ////////////////////////////////////////
    // Latched address word, A[31:12]
    ////////////////////////////////////////

    typedef union packed {
        // Zorro II memory-map view
        struct packed {
            logic [7:0] highByte;   // A[31:24]
            logic [2:0] bank;       // A[23:21]
            logic [1:0] subBank;    // A[20:19]
            logic [6:0] page;       // A[18:12], bit 0 is A12
        } map;
        // CPU-space view for interrupt acknowledge
        struct packed {
            logic [15:0] upperSixteen;
            logic [3:0]  lowNibble;
        } cpu;
    } addrWord_u;

    // Space a cycle resolved to
    typedef enum logic [2:0] {
        spNone,
        spRom,
        spCia,
        spChipRam,
        spChipReg,
        spAutovec,
        spLocal
    } space_e;

    // Fixed map bytes, compared against A[23:16]
    localparam logic [7:0] CIA_BYTE      = 8'hBF;
    localparam logic [7:0] REG_BYTE      = 8'hDF;
    // High ROM, compared against A[23:19]
    localparam logic [4:0] ROM_HIGH_BITS = 5'b11111;

endpackage

`default_nettype wire

/* src/spaceIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface spaceIf import busPkg::*; ();

    // Latched cycle from the controller
    addrWord_u  addr;
    logic [1:0] tt;
    logic       lbClaim;
    logic       valid;
    // Boot overlay from the CIA block
    logic       ovl;
    // Decode result
    space_e     space;
    logic       known;

    modport decoder (input addr, ovl, lbClaim, tt, valid, output space, known);
    modport controller (output addr, tt, lbClaim, valid, input space, known);

endinterface

`default_nettype wire

/* src/addressDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module addressDecode import busPkg::*; (
    spaceIf.decoder sIf
);

    addrWord_u a;
    logic      z2Space;
    logic      romHit;
    logic      ciaHit;
    logic      ramHit;
    logic      regHit;
    logic      avecHit;

    assign a = sIf.addr;

    ////////////////////////////////////////
    // Memory-map view
    ////////////////////////////////////////

    // Low 16MB only
    assign z2Space = a.map.highByte == 8'h00;

    // Reset vector while overlaid, plus $F8-$FF always
    assign romHit = z2Space &&
                    ((sIf.ovl && a.map.bank == 3'b000) ||
                     ({a.map.bank, a.map.subBank} == ROM_HIGH_BITS));

    assign ciaHit = z2Space &&
                    {a.map.bank, a.map.subBank, a.map.page[6:4]} == CIA_BYTE;

    // Chip RAM shows through once the overlay drops
    assign ramHit = z2Space && !sIf.ovl && a.map.bank == 3'b000;

    assign regHit = z2Space &&
                    {a.map.bank, a.map.subBank, a.map.page[6:4]} == REG_BYTE;

    ////////////////////////////////////////
    // CPU-space view
    ////////////////////////////////////////

    // Interrupt acknowledge, always autovectored
    assign avecHit = sIf.tt == 2'b11 && a.cpu.upperSixteen == 16'hFFFF;

    // Any claimant at all
    assign sIf.known = sIf.valid &&
                       (sIf.lbClaim || avecHit || romHit || ciaHit || regHit || ramHit);

    // Local bus wins over everything
    always_comb begin
        if (!sIf.valid) begin
            sIf.space = spNone;
        end else if (sIf.lbClaim) begin
            sIf.space = spLocal;
        end else if (avecHit) begin
            sIf.space = spAutovec;
        end else if (romHit) begin
            sIf.space = spRom;
        end else if (ciaHit) begin
            sIf.space = spCia;
        end else if (regHit) begin
            sIf.space = spChipReg;
        end else if (ramHit) begin
            sIf.space = spChipRam;
        end else begin
            sIf.space = spNone;
        end
    end

    // Map regions never overlap, the priority chain would hide one
    always_comb begin
        assert final (!sIf.valid || $onehot0({romHit, ciaHit, regHit, ramHit}))
            else $error("overlapping memory-map regions decoded");
    end

endmodule

`default_nettype wire

/* src/ciaAccess.sv */
`timescale 1ns/1ps
`default_nettype none

module ciaAccess #(
    parameter int E_DIV = 10
) (
    input  logic clk40,
    input  logic rst,
    input  logic ciaStart,
    input  logic rw,
    input  logic addr12,
    input  logic addr13,
    input  logic data0,
    output logic eClk,
    output logic nCiaCs0,
    output logic nCiaCs1,
    output logic ciaDone,
    output logic ovl
);

    localparam int E_LOW = E_DIV * 6 / 10;
    localparam int CW    = $clog2(E_DIV);

    logic [CW-1:0] phaseCnt;
    logic          eRise;
    logic          eFall;
    logic          pending;
    logic          csActive;

    ////////////////////////////////////////
    // E clock
    ////////////////////////////////////////

    // Both one cycle ahead of eClk itself
    assign eRise = phaseCnt == CW'(E_LOW - 1);
    assign eFall = phaseCnt == CW'(E_DIV - 1);

    always_ff @(posedge clk40) begin
        if (rst) begin
            phaseCnt <= '0;
            eClk     <= 1'b0;
        end else begin
            phaseCnt <= eFall ? '0 : phaseCnt + 1'b1;
            if (eRise) begin
                eClk <= 1'b1;
            end else if (eFall) begin
                eClk <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Chip selects and overlay
    ////////////////////////////////////////

    always_ff @(posedge clk40) begin
        if (rst) begin
            pending  <= 1'b0;
            csActive <= 1'b0;
            nCiaCs0  <= 1'b1;
            nCiaCs1  <= 1'b1;
            ciaDone  <= 1'b0;
            ovl      <= 1'b1;
        end else begin
            ciaDone <= 1'b0;
            if (eRise && (pending || ciaStart)) begin
                // CIA-A on A12 low, CIA-B on A13 low
                pending  <= 1'b0;
                csActive <= 1'b1;
                nCiaCs0  <= addr12;
                nCiaCs1  <= addr13;
            end else if (ciaStart) begin
                pending <= 1'b1;
            end
            if (eFall && csActive) begin
                csActive <= 1'b0;
                nCiaCs0  <= 1'b1;
                nCiaCs1  <= 1'b1;
                ciaDone  <= 1'b1;
                // CIA-A port A bit 0 written low
                if (!rw && !addr12 && !data0) begin
                    ovl <= 1'b0;
                end
            end
        end
    end

    // Selects confined to the E-high phase
    assert property (@(posedge clk40) disable iff (rst) (!nCiaCs0 || !nCiaCs1) |-> eClk)
        else $error("CIA select low outside E high");

    // One access at a time from the controller
    assert property (@(posedge clk40) disable iff (rst) ciaStart |-> !pending && !csActive)
        else $error("ciaStart while CIA access in flight");

endmodule

`default_nettype wire

/* src/cycleControl.sv */
`timescale 1ns/1ps
`default_nettype none

module cycleControl import busPkg::*; #(
    parameter int ROM_WAIT = 3
) (
    input  logic       clk40,
    input  logic       rst,
    input  logic       ts,
    input  logic [1:0] tt,
    input  logic       rw,
    input  addrWord_u  addr,
    input  logic       lbClaim,
    input  logic       data0,
    input  logic       chipAck,
    input  logic       ciaDone,
    spaceIf.controller sIf,
    output logic       ta,
    output logic       tea,
    output logic       avec,
    output logic       romEn,
    output logic       chipRamReq,
    output logic       chipRegReq,
    output logic       busy,
    output logic       ciaStart,
    output logic       ciaRw,
    output logic       ciaData0
);

    localparam int CW = (ROM_WAIT > 1) ? $clog2(ROM_WAIT) : 1;

    localparam logic [2:0] stIdle   = 3'd0;
    localparam logic [2:0] stDecode = 3'd1;
    localparam logic [2:0] stCount  = 3'd2;
    localparam logic [2:0] stChip   = 3'd3;
    localparam logic [2:0] stCia    = 3'd4;
    localparam logic [2:0] stTerm   = 3'd5;

    logic [2:0]    state;
    logic [CW-1:0] waitCnt;
    logic          accept;
    logic          errCyc;
    space_e        cycSpace;
    addrWord_u     addrLat;
    logic [1:0]    ttLat;
    logic          lbLat;
    logic          rwLat;
    logic          d0Lat;
    logic          valid;

    assign accept = ts && state == stIdle;

    // Latched cycle to decoder and CIA block
    assign sIf.addr    = addrLat;
    assign sIf.tt      = ttLat;
    assign sIf.lbClaim = lbLat;
    assign sIf.valid   = valid;
    assign ciaRw       = rwLat;
    assign ciaData0    = d0Lat;

    always_ff @(posedge clk40) begin
        if (accept) begin
            addrLat <= addr;
            ttLat   <= tt;
            lbLat   <= lbClaim;
            rwLat   <= rw;
            d0Lat   <= data0;
        end
    end

    ////////////////////////////////////////
    // Termination FSM
    ////////////////////////////////////////

    always_ff @(posedge clk40) begin
        if (rst) begin
            state      <= stIdle;
            waitCnt    <= '0;
            errCyc     <= 1'b0;
            cycSpace   <= spNone;
            valid      <= 1'b0;
            ta         <= 1'b0;
            tea        <= 1'b0;
            avec       <= 1'b0;
            romEn      <= 1'b0;
            chipRamReq <= 1'b0;
            chipRegReq <= 1'b0;
            busy       <= 1'b0;
            ciaStart   <= 1'b0;
        end else begin
            ciaStart <= 1'b0;
            case (state)
                stIdle: begin
                    if (accept) begin
                        valid <= 1'b1;
                        state <= stDecode;
                    end
                end
                stDecode: begin
                    busy     <= 1'b1;
                    cycSpace <= sIf.space;
                    errCyc   <= !sIf.known;
                    waitCnt  <= '0;
                    case (sIf.space)
                        spRom: begin
                            romEn   <= 1'b1;
                            waitCnt <= CW'(ROM_WAIT - 1);
                            state   <= stCount;
                        end
                        spChipRam: begin
                            chipRamReq <= 1'b1;
                            state      <= stChip;
                        end
                        spChipReg: begin
                            chipRegReq <= 1'b1;
                            state      <= stChip;
                        end
                        spCia: begin
                            ciaStart <= 1'b1;
                            state    <= stCia;
                        end
                        // Unknown, autovector, local bus: one cycle
                        default: state <= stCount;
                    endcase
                end
                stCount: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else if (cycSpace == spLocal) begin
                        // local bus ends its own cycle
                        busy  <= 1'b0;
                        valid <= 1'b0;
                        state <= stIdle;
                    end else begin
                        ta    <= !errCyc;
                        tea   <= errCyc;
                        avec  <= cycSpace == spAutovec;
                        state <= stTerm;
                    end
                end
                stChip: begin
                    // Request held until the chipset answers
                    if (chipAck) begin
                        chipRamReq <= 1'b0;
                        chipRegReq <= 1'b0;
                        state      <= stCount;
                    end
                end
                stCia: begin
                    if (ciaDone) begin
                        ta    <= 1'b1;
                        state <= stTerm;
                    end
                end
                stTerm: begin
                    ta    <= 1'b0;
                    tea   <= 1'b0;
                    avec  <= 1'b0;
                    romEn <= 1'b0;
                    busy  <= 1'b0;
                    valid <= 1'b0;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    assert property (@(posedge clk40) disable iff (rst) !(ta && tea))
        else $error("ta and tea together");

    // Starts must wait out the whole cycle, decode cycle included
    assert property (@(posedge clk40) disable iff (rst) ts |-> !busy && !$past(ts))
        else $error("ts while a cycle is in flight");

endmodule

`default_nettype wire

/* src/busDecodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module busDecodeTop #(
    parameter int ROM_WAIT = 3,
    parameter int E_DIV    = 10
) (
    input  logic        clk40,
    input  logic        rst,
    input  logic        ts,
    input  logic [1:0]  tt,
    input  logic        rw,
    input  logic [19:0] addr,
    input  logic        lbClaim,
    input  logic        data0,
    input  logic        chipAck,
    output logic        ta,
    output logic        tea,
    output logic        avec,
    output logic        romEn,
    output logic        chipRamReq,
    output logic        chipRegReq,
    output logic        nCiaCs0,
    output logic        nCiaCs1,
    output logic        eClk,
    output logic        busy
);

    logic ovl;
    logic ciaStart;
    logic ciaDone;
    logic ciaRw;
    logic ciaData0;

    spaceIf spaceBus ();

    // Overlay feeds the map decode
    assign spaceBus.ovl = ovl;

    addressDecode decoder (
        .sIf (spaceBus.decoder)
    );

    ////////////////////////////////////////
    // CIA side, A12/A13 from the latch
    ////////////////////////////////////////

    ciaAccess #(
        .E_DIV (E_DIV)
    ) ciaSeq (
        .clk40    (clk40),
        .rst      (rst),
        .ciaStart (ciaStart),
        .rw       (ciaRw),
        .addr12   (spaceBus.addr.map.page[0]),
        .addr13   (spaceBus.addr.map.page[1]),
        .data0    (ciaData0),
        .eClk     (eClk),
        .nCiaCs0  (nCiaCs0),
        .nCiaCs1  (nCiaCs1),
        .ciaDone  (ciaDone),
        .ovl      (ovl)
    );

    cycleControl #(
        .ROM_WAIT (ROM_WAIT)
    ) cycleCtl (
        .clk40      (clk40),
        .rst        (rst),
        .ts         (ts),
        .tt         (tt),
        .rw         (rw),
        .addr       (addr),
        .lbClaim    (lbClaim),
        .data0      (data0),
        .chipAck    (chipAck),
        .ciaDone    (ciaDone),
        .sIf        (spaceBus.controller),
        .ta         (ta),
        .tea        (tea),
        .avec       (avec),
        .romEn      (romEn),
        .chipRamReq (chipRamReq),
        .chipRegReq (chipRegReq),
        .busy       (busy),
        .ciaStart   (ciaStart),
        .ciaRw      (ciaRw),
        .ciaData0   (ciaData0)
    );

endmodule

`default_nettype wire

/* test/tbBusDecodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbBusDecodeTop import busPkg::*; ();

    localparam int ROM_WAIT   = 3;
    localparam int E_DIV      = 10;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_CYCLES = 400;
    localparam int SEED       = 69784;
    // E low for the first 60% of each period
    localparam int E_LOW      = E_DIV * 6 / 10;
    // Worst-case CIA cycle per start, plus reset margin
    localparam int WATCHDOG_NS = (NUM_CYCLES * (2 * E_DIV + 4) + 20) * CLK_PERIOD;

    logic        clk40;
    logic        rst;
    logic        ts;
    logic [1:0]  tt;
    logic        rw;
    logic [19:0] addr;
    logic        lbClaim;
    logic        data0;
    logic        chipAck;
    logic        ta;
    logic        tea;
    logic        avec;
    logic        romEn;
    logic        chipRamReq;
    logic        chipRegReq;
    logic        nCiaCs0;
    logic        nCiaCs1;
    logic        eClk;
    logic        busy;

    // Model of the cycle in flight
    logic   mActive;
    logic   termSeen;
    logic   ackSeen;
    logic   csSeen;
    logic   mOvl;
    logic   mA12;
    logic   mA13;
    logic   mRw;
    logic   mD0;
    int     age;
    int     ackAge;
    space_e mSpace;
    int     ePhase;

    int cycCnt  [1:5];
    int failCnt [1:5];
    int issued;

    busDecodeTop #(
        .ROM_WAIT (ROM_WAIT),
        .E_DIV    (E_DIV)
    ) dut_i (.*);

    initial begin
        clk40 = 1'b0;
        forever #(CLK_PERIOD / 2) clk40 = ~clk40;
    end

    ////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////

    // addr holds A[31:12], so A[23:16] sits at [11:4]
    function automatic space_e modelSpace(input logic [19:0] a, input logic [1:0] t,
                                          input logic lb, input logic ov);
        if (lb) return spLocal;
        if (t == 2'b11 && a[19:4] == 16'hFFFF) return spAutovec;
        if (a[19:12] != 8'h00) return spNone;
        if (a[11:7] == ROM_HIGH_BITS || (ov && a[11:9] == 3'b000)) return spRom;
        if (a[11:4] == CIA_BYTE) return spCia;
        if (a[11:4] == REG_BYTE) return spChipReg;
        if (a[11:9] == 3'b000) return spChipRam;
        return spNone;
    endfunction

    function automatic int behaviorOf(input space_e s);
        case (s)
            spAutovec: return 2;
            spRom: return 3;
            spChipRam, spChipReg: return 4;
            spCia: return 5;
            default: return 1;
        endcase
    endfunction

    task automatic reportMismatch(input int beh, input string msg);
        $display("MISMATCH at %0d ns: behavior %0d, %s", $time, beh, msg);
        failCnt[beh] = failCnt[beh] + 1;
    endtask

    // Free-running E clock phase since reset
    always @(posedge clk40) begin
        if (rst) begin
            ePhase <= 0;
        end else begin
            ePhase <= (ePhase == E_DIV - 1) ? 0 : ePhase + 1;
        end
    end

    // age counts the edges already past since the ts edge
    always @(posedge clk40) begin
        if (rst) begin
            mActive  <= 1'b0;
            termSeen <= 1'b0;
            mOvl     <= 1'b1;
        end else if (mActive && !termSeen) begin
            age <= age + 1;
            if (ta || tea || (mSpace == spLocal && age == 1)) begin
                termSeen <= 1'b1;
            end
            if (chipAck && age >= 1 && !ackSeen) begin
                ackSeen <= 1'b1;
                ackAge  <= age + 2;
            end
            if (!nCiaCs0 || !nCiaCs1) begin
                csSeen <= 1'b1;
            end
            // Write to CIA-A with bit 0 low drops the overlay
            if (mSpace == spCia && ta && !mRw && !mA12 && !mD0) begin
                mOvl <= 1'b0;
            end
        end else begin
            mActive <= ts;
            if (ts) begin
                age      <= 0;
                termSeen <= 1'b0;
                ackSeen  <= 1'b0;
                csSeen   <= 1'b0;
                mSpace   <= modelSpace(addr, tt, lbClaim, mOvl);
                mA12     <= addr[0];
                mA13     <= addr[1];
                mRw      <= rw;
                mD0      <= data0;
                cycCnt[behaviorOf(modelSpace(addr, tt, lbClaim, mOvl))]++;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clk40) disable iff (rst)
        mActive |-> busy == (age >= 1 && !termSeen))
        else reportMismatch(behaviorOf(mSpace), "busy wrong");

    // Nothing driven between cycles
    assert property (@(posedge clk40) disable iff (rst)
        (!mActive || termSeen) |-> !ta && !tea && !avec && !romEn && !chipRamReq && !chipRegReq)
        else reportMismatch(behaviorOf(mSpace), "strobe or request outside a cycle");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && mSpace == spNone) |-> tea == (age == 2) && !ta && !avec)
        else reportMismatch(1, "unknown space not ended by tea at edge 2");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && mSpace == spLocal) |-> !ta && !tea && !avec && age <= 1)
        else reportMismatch(1, "local-bus claim got a termination");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && mSpace == spAutovec) |->
            ta == (age == 2) && avec == (age == 2) && !tea)
        else reportMismatch(2, "autovector ta/avec not at edge 2");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && mSpace == spRom) |->
            romEn == (age >= 1) && ta == (age == 1 + ROM_WAIT) && !tea && !avec)
        else reportMismatch(3, "ROM enable or ta timing");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && mSpace != spRom) |-> !romEn)
        else reportMismatch(behaviorOf(mSpace), "romEn outside a ROM cycle");

    // Request up from edge 1 until chipAck, ta one edge after
    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen) |->
            chipRamReq == (mSpace == spChipRam && age >= 1 && !ackSeen) &&
            chipRegReq == (mSpace == spChipReg && age >= 1 && !ackSeen))
        else reportMismatch(behaviorOf(mSpace), "chipset request wrong");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && (mSpace == spChipRam || mSpace == spChipReg)) |->
            ta == (ackSeen && age == ackAge) && !tea && !avec)
        else reportMismatch(4, "chipset ta not one cycle after chipAck");

    // E clock waveform against the phase count
    assert property (@(posedge clk40) disable iff (rst)
        eClk == (ePhase >= E_LOW))
        else reportMismatch(5, "E clock phase wrong");

    // Selects only in a CIA cycle, only while E high
    assert property (@(posedge clk40) disable iff (rst)
        (!nCiaCs0 || !nCiaCs1) |->
            eClk && mActive && !termSeen && mSpace == spCia &&
            nCiaCs0 == mA12 && nCiaCs1 == mA13)
        else reportMismatch(5, "CIA select low at the wrong time or wrong chip");

    assert property (@(posedge clk40) disable iff (rst)
        (mActive && !termSeen && mSpace == spCia) |->
            !tea && !avec && age <= 2 * E_DIV + 3 && (!ta || csSeen || (mA12 && mA13)))
        else reportMismatch(5, "CIA cycle late or ended before its select");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Weighted address class, then one full cycle
    task automatic issueCycle();
        int r;
        r       = $urandom_range(99, 0);
        lbClaim = 1'b0;
        tt      = 2'($urandom_range(2, 0));
        rw      = 1'($urandom);
        data0   = 1'($urandom);
        if (r < 12) begin
            addr = {8'($urandom_range(255, 1)), 12'($urandom)};
        end else if (r < 20) begin
            lbClaim = 1'b1;
            addr    = 20'($urandom);
            tt      = 2'($urandom);
        end else if (r < 30) begin
            tt   = 2'b11;
            addr = {16'hFFFF, 4'($urandom)};
        end else if (r < 42) begin
            addr = {8'h00, ROM_HIGH_BITS, 7'($urandom)};
        end else if (r < 60) begin
            addr = {8'h00, 3'b000, 9'($urandom)};
        end else if (r < 82) begin
            // One of A13/A12 low picks CIA-B or CIA-A
            addr = {8'h00, CIA_BYTE, 2'($urandom),
                    ($urandom_range(1, 0) != 0) ? 2'b10 : 2'b01};
        end else if (r < 92) begin
            addr = {8'h00, REG_BYTE, 4'($urandom)};
        end else begin
            addr = 20'($urandom);
            tt   = 2'($urandom);
        end
        ts = 1'b1;
        @(negedge clk40);
        ts = 1'b0;
        do @(negedge clk40); while (!busy);
        while (busy) @(negedge clk40);
    endtask

    // Chipset model, answers after 0 to 5 cycles
    initial begin
        int delay;
        chipAck = 1'b0;
        forever begin
            @(negedge clk40);
            if (chipRamReq || chipRegReq) begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk40);
                chipAck = 1'b1;
                @(negedge clk40);
                chipAck = 1'b0;
            end
        end
    end

    initial begin
        int total;
        int fails;
        void'($urandom(SEED));
        rst     = 1'b1;
        ts      = 1'b0;
        tt      = 2'b00;
        rw      = 1'b1;
        addr    = '0;
        lbClaim = 1'b0;
        data0   = 1'b1;
        issued  = 0;
        for (int i = 1; i <= 5; i++) begin
            cycCnt[i]  = 0;
            failCnt[i] = 0;
        end
        repeat (10) @(negedge clk40);
        rst = 1'b0;
        repeat (2) @(negedge clk40);
        for (int n = 0; n < NUM_CYCLES; n++) begin
            repeat ($urandom_range(2, 0)) @(negedge clk40);
            issueCycle();
            issued++;
        end
        repeat (4) @(negedge clk40);

        $display("behavior 1 unknown and local bus: %0d cycles, %0d failures",
                 cycCnt[1], failCnt[1]);
        $display("behavior 2 autovector: %0d cycles, %0d failures", cycCnt[2], failCnt[2]);
        $display("behavior 3 ROM: %0d cycles, %0d failures", cycCnt[3], failCnt[3]);
        $display("behavior 4 chip RAM and registers: %0d cycles, %0d failures",
                 cycCnt[4], failCnt[4]);
        $display("behavior 5 CIA: %0d cycles, %0d failures", cycCnt[5], failCnt[5]);
        total = 0;
        fails = 0;
        for (int i = 1; i <= 5; i++) begin
            total += cycCnt[i];
            fails += failCnt[i];
        end
        $display("%0d cycles checked, %0d failures", total, fails);
        if (fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Hung handshake guard
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, only %0d of %0d cycles completed",
                 WATCHDOG_NS, issued, NUM_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/busPkg.sv
src/spaceIf.sv
src/addressDecode.sv
src/ciaAccess.sv
src/cycleControl.sv
src/busDecodeTop.sv
test/tbBusDecodeTop.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bus decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f list.f --top-module tbBusDecodeTop \
    -Mdir obj_dir -o simv \
    && ./obj_dir/simv | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -qx "test passed" sim.log && exit 0 || exit 1
